// File: build.f
hw/mac_pkg.sv
hw/mac_crc.sv
hw/mac_rx_deframer.sv
hw/mac_tx_framer.sv
hw/mac_core.sv
verif/tb_mac_core.sv

// File: hw/mac_core.sv
// gigabit MAC framing top: receive deframer and transmit framer, each with its own CRC engine
module mac_core (
    input  logic       mac_rx_clk,
    input  logic       rst_n_i,
    // receive, phy side
    input  logic       phy_rx_dv_i,
    input  logic       phy_rx_er_i,
    input  logic [7:0] phy_rxd_i,
    // receive, logic side
    output logic       mac_rx_sof_o,
    output logic       mac_rx_eof_o,
    output logic       mac_rx_valid_o,
    output logic [7:0] mac_rx_data_o,
    output logic [3:0] eth_status_o,
    // transmit, logic side
    input  logic       mac_tx_sof_i,
    input  logic       mac_tx_eof_i,
    input  logic       mac_tx_valid_i,
    input  logic [7:0] mac_tx_data_i,
    // transmit, phy side
    output logic       phy_tx_en_o,
    output logic [7:0] phy_txd_o
);

    logic        rx_crc_clear;
    logic        rx_crc_en;
    logic [7:0]  rx_crc_data;
    logic [31:0] rx_crc;
    logic        tx_crc_clear;
    logic        tx_crc_en;
    logic [31:0] tx_crc;

    // ------------------------------
    // receive channel
    // ------------------------------
    mac_rx_deframer u_rx (
        .mac_rx_clk     (mac_rx_clk),
        .rst_n_i        (rst_n_i),
        .phy_rx_dv_i    (phy_rx_dv_i),
        .phy_rx_er_i    (phy_rx_er_i),
        .phy_rxd_i      (phy_rxd_i),
        .crc_i          (rx_crc),
        .crc_clear_o    (rx_crc_clear),
        .crc_en_o       (rx_crc_en),
        .crc_data_o     (rx_crc_data),
        .mac_rx_sof_o   (mac_rx_sof_o),
        .mac_rx_eof_o   (mac_rx_eof_o),
        .mac_rx_valid_o (mac_rx_valid_o),
        .mac_rx_data_o  (mac_rx_data_o),
        .eth_status_o   (eth_status_o)
    );

    mac_crc u_rx_crc (
        .mac_rx_clk (mac_rx_clk),
        .rst_n_i    (rst_n_i),
        .clear_i    (rx_crc_clear),
        .en_i       (rx_crc_en),
        .data_i     (rx_crc_data),
        .crc_o      (rx_crc)
    );

    // ------------------------------
    // transmit channel
    // ------------------------------
    mac_tx_framer u_tx (
        .mac_rx_clk     (mac_rx_clk),
        .rst_n_i        (rst_n_i),
        .mac_tx_sof_i   (mac_tx_sof_i),
        .mac_tx_eof_i   (mac_tx_eof_i),
        .mac_tx_valid_i (mac_tx_valid_i),
        .mac_tx_data_i  (mac_tx_data_i),
        .crc_i          (tx_crc),
        .crc_clear_o    (tx_crc_clear),
        .crc_en_o       (tx_crc_en),
        .phy_tx_en_o    (phy_tx_en_o),
        .phy_txd_o      (phy_txd_o)
    );

    // fcs is computed on the undelayed stream
    mac_crc u_tx_crc (
        .mac_rx_clk (mac_rx_clk),
        .rst_n_i    (rst_n_i),
        .clear_i    (tx_crc_clear),
        .en_i       (tx_crc_en),
        .data_i     (mac_tx_data_i),
        .crc_o      (tx_crc)
    );

endmodule

// File: hw/mac_crc.sv
// byte-wide ethernet CRC-32 register with clear and enable, one instance per MAC channel
module mac_crc (
    input  logic        mac_rx_clk,
    input  logic        rst_n_i,
    input  logic        clear_i,
    input  logic        en_i,
    input  logic [7:0]  data_i,
    output logic [31:0] crc_o
);

    import mac_pkg::*;

    // eight serial steps folded into one cycle
    // data enters lsb first, register moves toward its msb
    function automatic logic [31:0] crc_next(
        input logic [31:0] crc,
        input logic [7:0]  data
    );
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[31] ^ data[i]) begin
                c = {c[30:0], 1'b0} ^ CRC_POLY;
            end else begin
                c = {c[30:0], 1'b0};
            end
        end
        return c;
    endfunction

    // clear wins over enable
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            crc_o <= CRC_INIT;
        end else if (clear_i) begin
            crc_o <= CRC_INIT;
        end else if (en_i) begin
            crc_o <= crc_next(crc_o, data_i);
        end
    end

    // both channels keep their preset and feed windows apart
    a_clear_en_excl: assert property (
        @(posedge mac_rx_clk) disable iff (!rst_n_i)
        !(clear_i && en_i)
    );

endmodule

// File: hw/mac_pkg.sv
// frame and CRC-32 constants shared by the MAC channels and the testbench, imported by wildcard
package mac_pkg;

    // ------------------------------
    // preamble and delimiter
    // ------------------------------
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE = 8'hD5;
    // seven preamble bytes plus the delimiter
    localparam int PREAMBLE_LEN = 8;

    // ------------------------------
    // frame check sequence
    // ------------------------------
    localparam int FCS_LEN = 4;
    // register preset at frame start
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;
    // ethernet generator, msb-first register form
    localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;
    // left in the register once a good frame and its fcs went through
    localparam logic [31:0] CRC_RESIDUE = 32'hC704_DD7B;

    // ------------------------------
    // derived sizes
    // ------------------------------
    // rx byte counter, saturates one past the first payload byte
    localparam int RX_CNT_W = $clog2(PREAMBLE_LEN + 2);
    // tx payload delay, makes room for preamble and delimiter
    localparam int TX_DLY = PREAMBLE_LEN + 1;
    // tx fcs slot tracker
    // covers the store cycle, the delay, the fcs bytes and the enable drop
    localparam int TX_FCS_FLAG_W = PREAMBLE_LEN + FCS_LEN + 2;

endpackage

// File: hw/mac_rx_deframer.sv
// receive channel: registers phy bytes, keeps link status, strips preamble and flags good frames
module mac_rx_deframer (
    input  logic        mac_rx_clk,
    input  logic        rst_n_i,
    // phy side, byte domain
    input  logic        phy_rx_dv_i,
    input  logic        phy_rx_er_i,
    input  logic [7:0]  phy_rxd_i,
    // sibling crc engine
    input  logic [31:0] crc_i,
    output logic        crc_clear_o,
    output logic        crc_en_o,
    output logic [7:0]  crc_data_o,
    // logic side stream
    output logic        mac_rx_sof_o,
    output logic        mac_rx_eof_o,
    output logic        mac_rx_valid_o,
    output logic [7:0]  mac_rx_data_o,
    output logic [3:0]  eth_status_o
);

    import mac_pkg::*;

    logic                rx_dv_d;
    logic                rx_er_d;
    logic [7:0]          rx_data_d;
    logic [RX_CNT_W-1:0] rx_cnt;
    logic [3:0]          eth_status_q;
    // stage 2 of the byte pipe
    logic [7:0]          rx_data_dd;
    logic                sof_dd;
    logic                pay_dd;
    // stage 3, crc result lines up here
    logic [7:0]          rx_data_q;
    logic                sof_q;
    logic                pay_q;
    logic                eof_q;
    logic                valid_next;

    // ------------------------------
    // input register
    // ------------------------------
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_dv_d   <= 1'b0;
            rx_er_d   <= 1'b0;
            rx_data_d <= '0;
        end else begin
            rx_dv_d   <= phy_rx_dv_i;
            rx_er_d   <= phy_rx_er_i;
            rx_data_d <= phy_rxd_i;
        end
    end

    // in-band status between frames
    // bit 0 link, bits 2..1 speed, bit 3 duplex
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            eth_status_q <= '0;
            eth_status_o <= '0;
        end else begin
            if (!rx_dv_d && !rx_er_d) begin
                eth_status_q <= rx_data_d[3:0];
            end
            eth_status_o <= eth_status_q;
        end
    end

    // ------------------------------
    // byte position and crc control
    // ------------------------------
    // index of the byte now in rx_data_d, preamble byte 0 first
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_cnt <= '0;
        end else if (!rx_dv_d) begin
            rx_cnt <= '0;
        end else if (rx_cnt != RX_CNT_W'(PREAMBLE_LEN + 1)) begin
            rx_cnt <= rx_cnt + 1'b1;
        end
    end

    // preset during preamble byte 6, feed from first byte past the sfd
    assign crc_clear_o = rx_dv_d && (rx_cnt == RX_CNT_W'(PREAMBLE_LEN - 2));
    assign crc_en_o    = rx_dv_d && (rx_cnt >= RX_CNT_W'(PREAMBLE_LEN));
    assign crc_data_o  = rx_data_d;

    // ------------------------------
    // output stream
    // ------------------------------
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_data_dd <= '0;
            sof_dd     <= 1'b0;
            pay_dd     <= 1'b0;
            rx_data_q  <= '0;
            sof_q      <= 1'b0;
            pay_q      <= 1'b0;
            eof_q      <= 1'b0;
        end else begin
            rx_data_dd <= rx_data_d;
            sof_dd     <= rx_dv_d && (rx_cnt == RX_CNT_W'(PREAMBLE_LEN));
            pay_dd     <= crc_en_o;
            rx_data_q  <= rx_data_dd;
            sof_q      <= sof_dd;
            pay_q      <= pay_dd;
            // crc_i already holds the byte sitting in rx_data_dd
            eof_q      <= pay_dd && (crc_i == CRC_RESIDUE);
        end
    end

    // held from sof until eof or the end of phy data
    assign valid_next = sof_q || (mac_rx_valid_o && !mac_rx_eof_o && pay_q);

    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mac_rx_data_o  <= '0;
            mac_rx_sof_o   <= 1'b0;
            mac_rx_eof_o   <= 1'b0;
            mac_rx_valid_o <= 1'b0;
        end else begin
            mac_rx_data_o  <= rx_data_q;
            mac_rx_sof_o   <= sof_q;
            mac_rx_eof_o   <= eof_q;
            mac_rx_valid_o <= valid_next;
        end
    end

    a_rx_marks_valid: assert property (
        @(posedge mac_rx_clk) disable iff (!rst_n_i)
        (mac_rx_sof_o || mac_rx_eof_o) |-> mac_rx_valid_o
    );

    a_rx_sof_eof_excl: assert property (
        @(posedge mac_rx_clk) disable iff (!rst_n_i)
        !(mac_rx_sof_o && mac_rx_eof_o)
    );

endmodule

// File: hw/mac_tx_framer.sv
// transmit channel: adds preamble and sfd in front of the delayed payload, appends the fcs
module mac_tx_framer (
    input  logic        mac_rx_clk,
    input  logic        rst_n_i,
    // logic side stream, no back-pressure
    input  logic        mac_tx_sof_i,
    input  logic        mac_tx_eof_i,
    input  logic        mac_tx_valid_i,
    input  logic [7:0]  mac_tx_data_i,
    // sibling crc engine, fed straight from the stream
    input  logic [31:0] crc_i,
    output logic        crc_clear_o,
    output logic        crc_en_o,
    // phy side
    output logic        phy_tx_en_o,
    output logic [7:0]  phy_txd_o
);

    import mac_pkg::*;

    function automatic logic [31:0] bit_reverse(input logic [31:0] value);
        logic [31:0] result;
        for (int i = 0; i < 32; i++) begin
            result[i] = value[31 - i];
        end
        return result;
    endfunction

    logic [7:0]               data_sr [TX_DLY];
    // walking ones, set by sof and eof, shift left each cycle
    logic [PREAMBLE_LEN-1:0]  pre_flag;
    logic [TX_FCS_FLAG_W-1:0] fcs_flag;
    logic [31:0]              fcs_value;
    logic [31:0]              fcs_stored;
    logic                     tx_busy;

    // engine presets between frames, runs over every valid byte
    assign crc_clear_o = !mac_tx_valid_i;
    assign crc_en_o    = mac_tx_valid_i;

    // wire order fcs, byte 0 goes out first
    assign fcs_value = bit_reverse(~crc_i);

    // ------------------------------
    // payload delay
    // ------------------------------
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < TX_DLY; i++) begin
                data_sr[i] <= '0;
            end
        end else begin
            data_sr[0] <= mac_tx_valid_i ? mac_tx_data_i : 8'h00;
            for (int i = 1; i < TX_DLY; i++) begin
                data_sr[i] <= data_sr[i - 1];
            end
        end
    end

    // ------------------------------
    // slot tracking
    // ------------------------------
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pre_flag <= '0;
            fcs_flag <= '0;
        end else begin
            pre_flag <= mac_tx_sof_i ? '1 : pre_flag << 1;
            fcs_flag <= mac_tx_eof_i ? '1 : fcs_flag << 1;
        end
    end

    // bit 0 only right after eof, crc_i holds the whole frame then
    always_ff @(posedge mac_rx_clk) begin
        if (fcs_flag[0]) begin
            fcs_stored <= fcs_value;
        end
    end

    // ------------------------------
    // output byte mux
    // ------------------------------
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phy_txd_o   <= '0;
            phy_tx_en_o <= 1'b0;
        end else begin
            phy_txd_o <= data_sr[TX_DLY - 1];
            // first seven slots after sof
            if (|pre_flag[PREAMBLE_LEN-2:0]) begin
                phy_txd_o <= PREAMBLE_BYTE;
            end
            // only the top flag bit left
            if (pre_flag[PREAMBLE_LEN-1] && !(|pre_flag[PREAMBLE_LEN-2:0])) begin
                phy_txd_o <= SFD_BYTE;
            end
            // lowest set flag bit picks the fcs byte
            for (int j = 0; j < FCS_LEN; j++) begin
                if (fcs_flag[TX_DLY + j] && !fcs_flag[TX_DLY + j - 1]) begin
                    phy_txd_o <= fcs_stored[8*j +: 8];
                end
            end
            if (pre_flag[0]) begin
                phy_tx_en_o <= 1'b1;
            end else if (fcs_flag[TX_DLY + FCS_LEN] && !fcs_flag[TX_DLY + FCS_LEN - 1]) begin
                phy_tx_en_o <= 1'b0;
            end
        end
    end

    // frame on the wire or still being framed
    assign tx_busy = phy_tx_en_o || (|pre_flag) || (|fcs_flag);

    a_tx_marks_valid: assert property (
        @(posedge mac_rx_clk) disable iff (!rst_n_i)
        (mac_tx_sof_i || mac_tx_eof_i) |-> mac_tx_valid_i
    );

    a_tx_sof_idle: assert property (
        @(posedge mac_rx_clk) disable iff (!rst_n_i)
        mac_tx_sof_i |-> !tx_busy
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the mac_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module tb_mac_core --Mdir obj_dir \
    && ./obj_dir/Vtb_mac_core > sim.log 2>&1
[ -f sim.log ] && cat sim.log
grep -qx "TEST PASS" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

// File: verif/tb_mac_core.sv
// testbench for mac_core: loops transmit back into receive, checks framing, fcs and status
module tb_mac_core;

    import mac_pkg::*;

    logic       mac_rx_clk = 1'b0;
    logic       rst_n_i;
    logic       phy_rx_dv_i;
    logic       phy_rx_er_i;
    logic [7:0] phy_rxd_i;
    logic       mac_rx_sof_o;
    logic       mac_rx_eof_o;
    logic       mac_rx_valid_o;
    logic [7:0] mac_rx_data_o;
    logic [3:0] eth_status_o;
    logic       mac_tx_sof_i;
    logic       mac_tx_eof_i;
    logic       mac_tx_valid_i;
    logic [7:0] mac_tx_data_i;
    logic       phy_tx_en_o;
    logic [7:0] phy_txd_o;

    // direct receive drive, used while the loop is off
    logic       loop_en;
    logic       rx_dv_drv;
    logic       rx_er_drv;
    logic [7:0] rxd_drv;
    // fault injection on the loop path
    logic       fault_en;
    int         fault_pos;
    int         wire_idx = 0;
    logic [7:0] fault_mask;

    // expected streams, frames in order
    logic [7:0] tx_exp_q [$];
    int         tx_len_q [$];
    logic [7:0] rx_exp_q [$];
    int         rx_len_q [$];
    logic       rx_good_q [$];
    int         tx_idx = 0;
    int         rx_idx = 0;
    int         cur_len = 0;
    logic       cur_good = 1'b0;
    int         rx_frames_done = 0;

    always #5 mac_rx_clk = ~mac_rx_clk;

    mac_core dut (.*);

    // index of the byte now on the wire, preamble byte 0 first
    always @(posedge mac_rx_clk) begin
        wire_idx <= phy_tx_en_o ? wire_idx + 1 : 0;
    end

    assign fault_mask = (fault_en && phy_tx_en_o && wire_idx == PREAMBLE_LEN + fault_pos)
                        ? 8'h5A : 8'h00;
    assign phy_rx_dv_i = loop_en ? phy_tx_en_o : rx_dv_drv;
    assign phy_rx_er_i = loop_en ? 1'b0 : rx_er_drv;
    assign phy_rxd_i   = loop_en ? (phy_txd_o ^ fault_mask) : rxd_drv;

    task automatic stop_with_failure();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_error(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic timeout_failed(input string msg);
        $display("timeout at time %0t: %s", $time, msg);
        stop_with_failure();
    endtask

    // ------------------------------
    // reference crc, reflected form
    // ------------------------------
    function automatic logic [31:0] reflect32(input logic [31:0] value);
        logic [31:0] result;
        for (int i = 0; i < 32; i++) begin
            result[i] = value[31 - i];
        end
        return result;
    endfunction

    // register shifts right here, so the fcs is simply its complement
    function automatic logic [31:0] crc_ref_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        logic [31:0] rpoly;
        rpoly = reflect32(CRC_POLY);
        c = crc ^ {24'h0, b};
        for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ rpoly) : (c >> 1);
        end
        return c;
    endfunction

    task automatic send_frame(input int len, input logic corrupt);
        logic [7:0]  payload [$];
        logic [31:0] crc;
        logic [31:0] fcs;
        crc = CRC_INIT;
        for (int i = 0; i < len; i++) begin
            payload.push_back(8'($urandom));
            crc = crc_ref_byte(crc, payload[i]);
        end
        fcs = ~crc;
        // the reference itself must land on the residue
        for (int j = 0; j < FCS_LEN; j++) begin
            crc = crc_ref_byte(crc, fcs[8*j +: 8]);
        end
        assert (reflect32(crc) == CRC_RESIDUE)
            else report_error("reference crc does not reach the residue");
        fault_en  = corrupt;
        fault_pos = int'($urandom_range(len - 1, 0));
        for (int i = 0; i < PREAMBLE_LEN - 1; i++) begin
            tx_exp_q.push_back(PREAMBLE_BYTE);
        end
        tx_exp_q.push_back(SFD_BYTE);
        for (int i = 0; i < len + FCS_LEN; i++) begin
            tx_exp_q.push_back(i < len ? payload[i] : fcs[8*(i - len) +: 8]);
            if (!corrupt) begin
                rx_exp_q.push_back(i < len ? payload[i] : fcs[8*(i - len) +: 8]);
            end
        end
        tx_len_q.push_back(PREAMBLE_LEN + len + FCS_LEN);
        rx_len_q.push_back(len + FCS_LEN);
        rx_good_q.push_back(!corrupt);
        for (int i = 0; i < len; i++) begin
            @(posedge mac_rx_clk);
            #1;
            mac_tx_valid_i = 1'b1;
            mac_tx_sof_i   = (i == 0);
            mac_tx_eof_i   = (i == len - 1);
            mac_tx_data_i  = payload[i];
        end
        @(posedge mac_rx_clk);
        #1;
        mac_tx_valid_i = 1'b0;
        mac_tx_sof_i   = 1'b0;
        mac_tx_eof_i   = 1'b0;
        mac_tx_data_i  = 8'h00;
        // required idle gap
        repeat (16) @(posedge mac_rx_clk);
    endtask

    task automatic wait_for_rx_frames(input int count);
        int cycles;
        cycles = 0;
        while (rx_frames_done < count) begin
            @(posedge mac_rx_clk);
            cycles++;
            if (cycles > 300) begin
                timeout_failed("receive stream did not deliver every frame");
            end
        end
    endtask

    // ------------------------------
    // stream checkers
    // ------------------------------
    always @(negedge mac_rx_clk) begin : tx_check
        logic [7:0] exp_byte;
        int         exp_len;
        if (phy_tx_en_o) begin
            assert (tx_exp_q.size() > 0) else report_error("tx enable high, no byte expected");
            exp_byte = tx_exp_q.pop_front();
            assert (phy_txd_o == exp_byte)
                else report_error($sformatf("tx byte %0d is %h, expected %h",
                                            tx_idx, phy_txd_o, exp_byte));
            tx_idx++;
        end else if (tx_idx != 0) begin
            assert (tx_len_q.size() > 0) else report_error("tx frame ended, none expected");
            exp_len = tx_len_q.pop_front();
            assert (tx_idx == exp_len)
                else report_error($sformatf("tx enable span of %0d bytes is wrong", tx_idx));
            tx_idx = 0;
        end
    end

    always @(negedge mac_rx_clk) begin : rx_check
        logic [7:0] exp_byte;
        if (mac_rx_valid_o) begin
            if (rx_idx == 0) begin
                assert (rx_len_q.size() > 0) else report_error("rx frame with none expected");
                cur_len  = rx_len_q.pop_front();
                cur_good = rx_good_q.pop_front();
            end
            assert (mac_rx_sof_o == (rx_idx == 0))
                else report_error($sformatf("rx sof wrong at byte %0d", rx_idx));
            assert (mac_rx_eof_o == (cur_good && rx_idx == cur_len - 1))
                else report_error($sformatf("rx eof wrong at byte %0d", rx_idx));
            if (cur_good) begin
                exp_byte = rx_exp_q.pop_front();
                assert (mac_rx_data_o == exp_byte)
                    else report_error($sformatf("rx byte %0d is %h, expected %h",
                                                rx_idx, mac_rx_data_o, exp_byte));
            end
            rx_idx++;
        end else if (rx_idx != 0) begin
            // also true for a bad frame, valid ends with phy data
            assert (rx_idx == cur_len)
                else report_error($sformatf("rx valid span of %0d bytes is wrong", rx_idx));
            rx_idx = 0;
            rx_frames_done++;
        end
    end

    // exact latencies of both channels
    a_tx_en_rise: assert property (@(posedge mac_rx_clk) disable iff (!rst_n_i)
        $past(mac_tx_sof_i, 2) |-> (phy_tx_en_o && !$past(phy_tx_en_o)))
        else report_error("tx enable did not rise one cycle after sof");
    a_tx_payload_lat: assert property (@(posedge mac_rx_clk) disable iff (!rst_n_i)
        $past(mac_tx_valid_i, 10) |-> (phy_txd_o == $past(mac_tx_data_i, 10)))
        else report_error("tx payload byte not 9 cycles behind its input");
    a_rx_payload_lat: assert property (@(posedge mac_rx_clk) disable iff (!rst_n_i)
        mac_rx_valid_o |-> (mac_rx_data_o == $past(phy_rxd_i, 4)))
        else report_error("rx byte not 3 cycles behind its input");
    // status nibble, 2 cycles through
    a_status_follow: assert property (@(posedge mac_rx_clk) disable iff (!rst_n_i)
        $past(!phy_rx_dv_i && !phy_rx_er_i, 3) |-> (eth_status_o == $past(phy_rxd_i[3:0], 3)))
        else report_error("status nibble not taken from an idle byte");
    a_status_hold: assert property (@(posedge mac_rx_clk) disable iff (!rst_n_i)
        $past(phy_rx_er_i, 3) |-> (eth_status_o == $past(eth_status_o)))
        else report_error("status nibble changed by an error byte");

    initial begin
        void'($urandom(33828));
        rst_n_i        = 1'b0;
        loop_en        = 1'b0;
        rx_dv_drv      = 1'b0;
        rx_er_drv      = 1'b0;
        rxd_drv        = 8'h00;
        fault_en       = 1'b0;
        fault_pos      = 0;
        mac_tx_sof_i   = 1'b0;
        mac_tx_eof_i   = 1'b0;
        mac_tx_valid_i = 1'b0;
        mac_tx_data_i  = 8'h00;
        repeat (2) @(posedge mac_rx_clk);
        #1;
        rst_n_i = 1'b1;
        @(negedge mac_rx_clk);
        assert (!mac_rx_valid_o && !mac_rx_sof_o && !mac_rx_eof_o && !phy_tx_en_o)
            else report_error("stream outputs not low after reset");
        assert (eth_status_o == 4'h0 && mac_rx_data_o == 8'h00 && phy_txd_o == 8'h00)
            else report_error("status or data outputs not zero after reset");
        // full duplex, speed 1, link up
        @(posedge mac_rx_clk);
        #1;
        rxd_drv = 8'h0B;
        repeat (4) @(posedge mac_rx_clk);
        #1;
        assert (eth_status_o == 4'hB) else report_error("status nibble not captured");
        rx_er_drv = 1'b1;
        rxd_drv   = 8'h04;
        repeat (4) @(posedge mac_rx_clk);
        #1;
        assert (eth_status_o == 4'hB) else report_error("status nibble lost on error");
        rx_er_drv = 1'b0;
        rxd_drv   = 8'h00;
        loop_en   = 1'b1;
        repeat (4) @(posedge mac_rx_clk);
        #1;
        // frame 3 is hit on the loop path
        for (int f = 0; f < 6; f++) begin
            send_frame(int'($urandom_range(40, 2)), f == 3);
        end
        wait_for_rx_frames(6);
        if (tx_exp_q.size() != 0 || rx_exp_q.size() != 0) begin
            report_error("expected bytes left over after the last frame");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule
